/* srpt_pkg.sv */
package srpt_pkg;

   // peer and rpc id width
   localparam int ID_W = 14;
   // packet counts and header length fields
   localparam int PKT_W = 10;

   // encoding kept identical to the request/entry codes on the wire
   // only EMPTY, BLOCKED and ACTIVE are produced by this queue
   typedef enum logic [2:0] {
      UPDATE     = 3'd0,
      BLOCK      = 3'd1,
      INVALIDATE = 3'd2,
      UNBLOCK    = 3'd3,
      EMPTY      = 3'd4,
      BLOCKED    = 3'd5,
      ACTIVE     = 3'd6
   } srpt_state_e;

   // one queue entry, 51 bits, msb first
   typedef struct packed {
      logic [ID_W-1:0]  peer_id;
      logic [ID_W-1:0]  rpc_id;
      logic [PKT_W-1:0] recv_pkts;
      logic [PKT_W-1:0] grantable_pkts;
      srpt_state_e      state;
   } srpt_entry_t;

   // incoming DATA packet header, 58 bits, msb first
   typedef struct packed {
      logic [ID_W-1:0]  peer_id;
      logic [ID_W-1:0]  rpc_id;
      logic [PKT_W-1:0] msg_len;
      logic [PKT_W-1:0] incoming;
      logic [PKT_W-1:0] offset;
   } srpt_header_t;

   // fill value for unused queue positions
   localparam srpt_entry_t SRPT_EMPTY_ENTRY = '{
      peer_id:        '0,
      rpc_id:         '0,
      recv_pkts:      '0,
      grantable_pkts: '0,
      state:          EMPTY
   };

   // ranking rule, true when a must sit strictly ahead of b
   // ACTIVE > BLOCKED > EMPTY, higher code wins
   // same state: fewer grantable packets wins
   // equal entries return false so the older one keeps its place
   function automatic logic srpt_before(input srpt_entry_t a, input srpt_entry_t b);
      logic result;
      if (a.state != b.state) begin
         result = (a.state > b.state);
      end else begin
         result = (a.grantable_pkts < b.grantable_pkts);
      end
      return result;
   endfunction

endpackage

/* srpt_header_intake.sv */
`timescale 1ns/10ps

module srpt_header_intake (
   input  logic                  ap_clk,
   input  logic                  ap_rst,
   input  logic                  header_valid_i,
   input  srpt_pkg::srpt_header_t header_i,
   input  srpt_pkg::srpt_entry_t  head_i,
   output logic                  push_o,
   output srpt_pkg::srpt_entry_t  new_entry_o
);

   import srpt_pkg::*;

   logic        accept;
   logic        peer_hit;
   srpt_entry_t entry_d;

   // first unscheduled packet with something left to grant
   assign accept = header_valid_i
                   && (header_i.offset == '0)
                   && (header_i.msg_len > header_i.incoming);

   // hit only on the peer of a live, non-EMPTY head
   assign peer_hit = (head_i.state != EMPTY) && (header_i.peer_id == head_i.peer_id);

   // entry built straight from the header
   always_comb begin
      entry_d.peer_id        = header_i.peer_id;
      entry_d.rpc_id         = header_i.rpc_id;
      // the packet carrying this header
      entry_d.recv_pkts      = PKT_W'(1);
      entry_d.grantable_pkts = header_i.msg_len - PKT_W'(1);
      entry_d.state          = peer_hit ? BLOCKED : ACTIVE;
   end

   // push strobe one cycle after the header edge
   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         push_o <= 1'b0;
      end else begin
         push_o <= accept;
      end
   end

   // payload is only meaningful while push_o is high
   always_ff @(posedge ap_clk) begin
      if (accept) begin
         new_entry_o <= entry_d;
      end
   end

endmodule

/* srpt_slot.sv */
`timescale 1ns/10ps

module srpt_slot (
   input  logic                 ap_clk,
   input  logic                 ap_rst,
   input  logic                 push_i,
   input  logic                 pop_i,
   input  srpt_pkg::srpt_entry_t new_entry_i,
   input  srpt_pkg::srpt_entry_t prev_entry_i,
   input  logic                 prev_take_i,
   input  srpt_pkg::srpt_entry_t next_entry_i,
   output srpt_pkg::srpt_entry_t entry_o,
   output logic                 take_o
);

   import srpt_pkg::*;

   srpt_entry_t entry_q;

   assign entry_o = entry_q;

   // new entry ranks ahead of what this slot holds
   // chain is sorted, so once high it stays high toward the tail
   assign take_o = push_i && srpt_before(new_entry_i, entry_q);

   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         entry_q <= SRPT_EMPTY_ENTRY;
      end else if (push_i) begin
         if (prev_take_i) begin
            // insertion point is above us, shift down one place
            entry_q <= prev_entry_i;
         end else if (take_o) begin
            // insertion point is exactly here
            entry_q <= new_entry_i;
         end
      end else if (pop_i) begin
         // head left the queue, everything moves up
         entry_q <= next_entry_i;
      end
   end

   // grant stage must hold off pops during a push
   assert property (@(posedge ap_clk) disable iff (ap_rst)
      !(push_i && pop_i));

   // take flags are monotonic along the chain
   // a break here would duplicate or lose an entry
   assert property (@(posedge ap_clk) disable iff (ap_rst)
      (push_i && prev_take_i) |-> take_o);

   // chain order holds against the slot above
   // slot 0 sees an EMPTY neighbour, which says nothing about order
   assert property (@(posedge ap_clk) disable iff (ap_rst)
      (!push_i && (prev_entry_i.state != EMPTY)) |-> !srpt_before(entry_q, prev_entry_i));

endmodule

/* srpt_grant_issue.sv */
`timescale 1ns/10ps

module srpt_grant_issue (
   input  logic                 ap_clk,
   input  logic                 ap_rst,
   input  logic                 grant_req_i,
   input  logic                 push_i,
   input  srpt_pkg::srpt_entry_t head_i,
   output logic                 pop_o,
   output logic                 grant_valid_o,
   output srpt_pkg::srpt_entry_t grant_o
);

   import srpt_pkg::*;

   // request that lost to a push and waits for it to clear
   logic req_wait_q;
   logic req_any;

   assign req_any = grant_req_i || req_wait_q;

   // push wins and the pop waits a cycle
   assign pop_o = req_any && (head_i.state != EMPTY) && !push_i;

   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         req_wait_q    <= 1'b0;
         grant_valid_o <= 1'b0;
      end else begin
         // keep waiting across back-to-back pushes
         req_wait_q    <= req_any && push_i;
         grant_valid_o <= pop_o;
      end
   end

   // grant payload holds the head seen at the pop edge
   always_ff @(posedge ap_clk) begin
      if (pop_o) begin
         grant_o <= head_i;
      end
   end

   // an issued grant always carries a real entry
   assert property (@(posedge ap_clk) disable iff (ap_rst)
      grant_valid_o |-> (grant_o.state inside {ACTIVE, BLOCKED}));

endmodule

/* srpt_grant_top.sv */
`timescale 1ns/10ps

module srpt_grant_top #(
   parameter int QUEUE_DEPTH = 8
) (
   input  logic                  ap_clk,
   input  logic                  ap_rst,
   input  logic                  header_valid_i,
   input  srpt_pkg::srpt_header_t header_i,
   input  logic                  grant_req_i,
   output logic                  grant_valid_o,
   output srpt_pkg::srpt_entry_t  grant_o
);

   import srpt_pkg::*;

   logic        push;
   logic        pop;
   srpt_entry_t new_entry;

   // slot contents and take flags, index 0 is the head
   srpt_entry_t slot_entry [QUEUE_DEPTH];
   logic        slot_take  [QUEUE_DEPTH];

   srpt_header_intake u_intake (
      .ap_clk         (ap_clk),
      .ap_rst         (ap_rst),
      .header_valid_i (header_valid_i),
      .header_i       (header_i),
      .head_i         (slot_entry[0]),
      .push_o         (push),
      .new_entry_o    (new_entry)
   );

   for (genvar k = 0; k < QUEUE_DEPTH; k++) begin : g_slot
      srpt_entry_t prev_entry;
      srpt_entry_t next_entry;
      logic        prev_take;

      // head end, nothing above
      if (k == 0) begin : g_head
         assign prev_entry = SRPT_EMPTY_ENTRY;
         assign prev_take  = 1'b0;
      end else begin : g_link_up
         assign prev_entry = slot_entry[k-1];
         assign prev_take  = slot_take[k-1];
      end

      // tail end, pops pull in an empty entry
      if (k == QUEUE_DEPTH-1) begin : g_tail
         assign next_entry = SRPT_EMPTY_ENTRY;
      end else begin : g_link_down
         assign next_entry = slot_entry[k+1];
      end

      srpt_slot u_slot (
         .ap_clk       (ap_clk),
         .ap_rst       (ap_rst),
         .push_i       (push),
         .pop_i        (pop),
         .new_entry_i  (new_entry),
         .prev_entry_i (prev_entry),
         .prev_take_i  (prev_take),
         .next_entry_i (next_entry),
         .entry_o      (slot_entry[k]),
         .take_o       (slot_take[k])
      );
   end

   srpt_grant_issue u_grant (
      .ap_clk        (ap_clk),
      .ap_rst        (ap_rst),
      .grant_req_i   (grant_req_i),
      .push_i        (push),
      .head_i        (slot_entry[0]),
      .pop_o         (pop),
      .grant_valid_o (grant_valid_o),
      .grant_o       (grant_o)
   );

endmodule

/* tb_srpt_grant.sv */
`timescale 1ns/10ps

module tb_srpt_grant;

   import srpt_pkg::*;

   localparam int QUEUE_DEPTH     = 4;
   localparam int RESET_CYCLES    = 5;
   localparam int CYCLES_PER_LINE = 12;
   localparam string GOLDEN_FILE  = "srpt_golden.txt";

   logic         ap_clk = 1'b0;
   logic         ap_rst;
   logic         header_valid_i;
   srpt_header_t header_i;
   logic         grant_req_i;
   logic         grant_valid_o;
   srpt_entry_t  grant_o;

   // command lines with their line numbers in the golden file
   string golden_lines [$];
   int    golden_line_no [$];
   int    total_lines = 0;
   logic  lines_loaded = 1'b0;

   // 4 ns period
   always #2 ap_clk = ~ap_clk;

   srpt_grant_top #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) dut_i (
      .ap_clk         (ap_clk),
      .ap_rst         (ap_rst),
      .header_valid_i (header_valid_i),
      .header_i       (header_i),
      .grant_req_i    (grant_req_i),
      .grant_valid_o  (grant_valid_o),
      .grant_o        (grant_o)
   );

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
   endtask

   function automatic string entry_text(input srpt_entry_t e);
      return $sformatf("%h/%h recv %0d grantable %0d %s", e.peer_id, e.rpc_id,
                       e.recv_pkts, e.grantable_pkts, e.state.name());
   endfunction

   // grant present and equal to the expected entry
   task automatic check_grant(input logic valid, input srpt_entry_t got,
                              input srpt_entry_t exp, input int line_no);
      if (valid !== 1'b1) begin
         abort_run($sformatf("ERROR at %0d ns: line %0d expected grant %s, grant_valid_o is %b",
                             $time, line_no, entry_text(exp), valid));
      end else if (got !== exp) begin
         abort_run($sformatf("ERROR at %0d ns: line %0d grant %s, expected %s",
                             $time, line_no, entry_text(got), entry_text(exp)));
      end
   endtask

   task automatic check_no_grant(input logic valid, input int line_no);
      if (valid !== 1'b0) begin
         abort_run($sformatf("ERROR at %0d ns: line %0d expected no grant, grant_valid_o is %b",
                             $time, line_no, valid));
      end
   endtask

   // second token of a grant line is the word none
   function automatic logic says_none(input string s);
      int i;
      i = 1;
      while (i < s.len() && s.getc(i) == " ") begin
         i++;
      end
      return (s.substr(i, i + 3) == "none");
   endfunction

   function automatic srpt_header_t make_header(input logic [31:0] f [10], input int base);
      srpt_header_t h;
      h.peer_id  = f[base][ID_W-1:0];
      h.rpc_id   = f[base+1][ID_W-1:0];
      h.msg_len  = f[base+2][PKT_W-1:0];
      h.incoming = f[base+3][PKT_W-1:0];
      h.offset   = f[base+4][PKT_W-1:0];
      return h;
   endfunction

   function automatic srpt_entry_t make_entry(input logic [31:0] f [10], input int base);
      srpt_entry_t e;
      e.peer_id        = f[base][ID_W-1:0];
      e.rpc_id         = f[base+1][ID_W-1:0];
      e.recv_pkts      = f[base+2][PKT_W-1:0];
      e.grantable_pkts = f[base+3][PKT_W-1:0];
      e.state          = srpt_state_e'(f[base+4][2:0]);
      return e;
   endfunction

   // keeps non-comment lines and counts every line for the watchdog
   task automatic load_golden();
      int    fd;
      string line;
      fd = $fopen(GOLDEN_FILE, "r");
      if (fd == 0) begin
         abort_run({"could not open the golden file ", GOLDEN_FILE});
      end
      while ($fgets(line, fd) != 0) begin
         total_lines++;
         if (line.len() > 1 && line.getc(0) != "#" && line.getc(0) != "\n") begin
            golden_lines.push_back(line);
            golden_line_no.push_back(total_lines);
         end
      end
      $fclose(fd);
      lines_loaded = 1'b1;
   endtask

   task automatic idle_gap();
      repeat ($urandom_range(3)) @(negedge ap_clk);
   endtask

   // covers the header edge and the push edge so the head is settled on return
   task automatic apply_header(input srpt_header_t hdr);
      header_valid_i = 1'b1;
      header_i       = hdr;
      @(negedge ap_clk);
      header_valid_i = 1'b0;
      @(negedge ap_clk);
   endtask

   // one-cycle request with the grant expected right after the sampling edge
   task automatic request_grant(input logic expect_grant, input srpt_entry_t exp,
                                input int line_no);
      grant_req_i = 1'b1;
      @(negedge ap_clk);
      grant_req_i = 1'b0;
      if (expect_grant) begin
         check_grant(grant_valid_o, grant_o, exp, line_no);
      end else begin
         check_no_grant(grant_valid_o, line_no);
      end
      @(negedge ap_clk);
      check_no_grant(grant_valid_o, line_no);
   endtask

   // request lands in the push cycle so the pop slips one edge
   task automatic header_with_request(input srpt_header_t hdr, input srpt_entry_t exp,
                                      input int line_no);
      header_valid_i = 1'b1;
      header_i       = hdr;
      @(negedge ap_clk);
      header_valid_i = 1'b0;
      grant_req_i    = 1'b1;
      @(negedge ap_clk);
      grant_req_i = 1'b0;
      // no grant yet at the push edge
      check_no_grant(grant_valid_o, line_no);
      @(negedge ap_clk);
      check_grant(grant_valid_o, grant_o, exp, line_no);
      @(negedge ap_clk);
      // the deferred request is served only once
      check_no_grant(grant_valid_o, line_no);
   endtask

   initial begin : stimulus
      string        line;
      byte          cmd;
      int           count;
      logic [31:0]  fld [10];
      srpt_entry_t  exp;
      void'($urandom(32'hddb4));
      ap_rst         = 1'b1;
      header_valid_i = 1'b0;
      header_i       = '0;
      grant_req_i    = 1'b0;
      load_golden();
      repeat (RESET_CYCLES) @(posedge ap_clk);
      @(negedge ap_clk);
      ap_rst = 1'b0;
      for (int n = 0; n < golden_lines.size(); n++) begin
         line = golden_lines[n];
         cmd  = line.getc(0);
         idle_gap();
         case (cmd)
            "H": begin
               count = $sscanf(line, "H %h %h %h %h %h", fld[0], fld[1], fld[2], fld[3], fld[4]);
               if (count != 5) begin
                  abort_run($sformatf("header line %0d of the golden file is malformed",
                                      golden_line_no[n]));
               end
               apply_header(make_header(fld, 0));
            end
            "G": begin
               count = $sscanf(line, "G %h %h %h %h %h", fld[0], fld[1], fld[2], fld[3], fld[4]);
               if (count == 5) begin
                  request_grant(1'b1, make_entry(fld, 0), golden_line_no[n]);
               end else if (says_none(line)) begin
                  request_grant(1'b0, SRPT_EMPTY_ENTRY, golden_line_no[n]);
               end else begin
                  abort_run($sformatf("grant line %0d of the golden file is malformed",
                                      golden_line_no[n]));
               end
            end
            "B": begin
               count = $sscanf(line, "B %h %h %h %h %h %h %h %h %h %h", fld[0], fld[1],
                               fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8], fld[9]);
               if (count != 10) begin
                  abort_run($sformatf("push-with-grant line %0d of the golden file is malformed",
                                      golden_line_no[n]));
               end
               exp = make_entry(fld, 5);
               header_with_request(make_header(fld, 0), exp, golden_line_no[n]);
            end
            default: begin
               abort_run($sformatf("unknown command on line %0d of the golden file",
                                   golden_line_no[n]));
            end
         endcase
      end
      $display("TEST PASSED");
      $finish;
   end

   // budget scales with the golden file length
   initial begin : watchdog
      wait (lines_loaded);
      repeat (RESET_CYCLES + total_lines * CYCLES_PER_LINE) @(posedge ap_clk);
      abort_run("watchdog expired before all golden commands were applied");
   end

endmodule

/* srpt_golden.txt */
# H peer rpc msg_len incoming offset        (push a header, all hex)
# G peer rpc recv grantable state | G none  (one-cycle grant request, state 6 ACTIVE 5 BLOCKED)
# B <five header fields> <five expected grant fields>  (request raised in the push cycle)
G none
H 0011 0001 008 000 004
H 0012 0002 005 005 000
H 0013 0003 003 007 000
G none
H 0021 0101 00a 000 000
G 0021 0101 001 009 6
H 0030 0200 010 000 000
H 0030 0201 004 001 000
G 0030 0200 001 00f 6
G 0030 0201 001 003 5
G none
H 0041 0301 008 000 000
H 0042 0302 003 000 000
H 0043 0303 008 000 000
H 0042 0304 002 000 000
G 0042 0302 001 002 6
G 0041 0301 001 007 6
G 0043 0303 001 007 6
G 0042 0304 001 001 5
G none
H 0051 0401 006 000 000
H 0052 0402 002 000 000
H 0053 0403 00a 000 000
H 0054 0404 004 000 000
H 0055 0405 003 000 000
G 0052 0402 001 001 6
G 0055 0405 001 002 6
G 0054 0404 001 003 6
G 0051 0401 001 005 6
G none
H 0061 0501 005 000 000
H 0062 0502 007 000 000
H 0063 0503 003 000 000
H 0064 0504 009 000 000
H 0063 0505 002 000 000
G 0063 0503 001 002 6
G 0061 0501 001 004 6
G 0062 0502 001 006 6
G 0064 0504 001 008 6
G none
H 0071 0601 009 000 000
B 0072 0602 003 000 000 0072 0602 001 002 6
G 0071 0601 001 008 6
G none
B 0081 0701 004 000 000 0081 0701 001 003 6
G none

/* sim.f */
srpt_pkg.sv
srpt_header_intake.sv
srpt_slot.sv
srpt_grant_issue.sv
srpt_grant_top.sv
tb_srpt_grant.sv

/* Makefile */
TOP = tb_srpt_grant

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
